// ==== sim.f ====
hdl/lms_data_pkg.sv
hdl/lms_ctrl_pkg.sv
hdl/converter_sequencer.sv
hdl/rx_iq_deinterleave.sv
hdl/tx_iq_interleave.sv
hdl/lms_frontend_top.sv
dv/lms_frontend_checker.sv
dv/lms_frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Run from the project root with Verilator 5 on the PATH
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert -Wno-fatal -f sim.f \
   --top-module lms_frontend_tb -o lms_frontend_sim \
   && ./obj_dir/lms_frontend_sim > "$LOG" 2>&1 \
   || echo ">>> FAIL" >> "$LOG"
cat "$LOG"
grep -q ">>> FAIL" "$LOG" && exit 1 || exit 0

// ==== dv/lms_frontend_tb.sv ====
// Default top-level parameters only (two channels, channel 0 inverted); tests share one run
`timescale 1ns/10ps

module lms_frontend_tb;

   localparam int              N_CH        = 2;
   localparam logic [N_CH-1:0] INVERT_MASK = 2'b01;   // Board default with channel 0 swapped
   localparam int              MAX_WORDS   = 128;
   localparam int              WAIT_LIMIT  = 40;      // Cycles before a wait gives up

   // Transmit words and the low 12 bits that reach the DAC
   localparam lms_data_pkg::dac_in_t   TX_I_WORD = 16'hA5C3;
   localparam lms_data_pkg::dac_in_t   TX_Q_WORD = 16'h3E71;
   localparam lms_data_pkg::dac_word_t TX_I_LOW  = 12'h5C3;
   localparam lms_data_pkg::dac_word_t TX_Q_LOW  = 12'hE71;

   logic                                 dsp_clk;
   logic                                 reset_i;
   logic                                 clock_ready;
   lms_data_pkg::adc_word_t [N_CH-1:0]   adc;
   logic [N_CH-1:0]                      rx_iq_sel;
   lms_data_pkg::sample_t [N_CH-1:0]     rx_sample_i;
   lms_data_pkg::sample_t [N_CH-1:0]     rx_sample_q;
   logic [N_CH-1:0]                      rx_valid;
   lms_data_pkg::dac_in_t                dac_i;
   lms_data_pkg::dac_in_t                dac_q;
   lms_data_pkg::dac_word_t              dac;
   logic                                 tx_iq_sel;
   logic                                 pll_reset;
   logic                                 frontend_run;

   lms_data_pkg::adc_word_t stim_word [N_CH][MAX_WORDS];   // ADC word queue per channel
   logic [31:0]             lfsr_state;
   int                      error_count;

   lms_frontend_top dut0
      (
      .dsp_clk        (dsp_clk),
      .reset_i        (reset_i),
      .clock_ready_i  (clock_ready),
      .adc_i          (adc),
      .rx_iq_sel_o    (rx_iq_sel),
      .rx_sample_i_o  (rx_sample_i),
      .rx_sample_q_o  (rx_sample_q),
      .rx_valid_o     (rx_valid),
      .dac_i_i        (dac_i),
      .dac_q_i        (dac_q),
      .dac_o          (dac),
      .tx_iq_sel_o    (tx_iq_sel),
      .pll_reset_o    (pll_reset),
      .frontend_run_o (frontend_run)
      );

   initial
   begin
      dsp_clk = 1'b0;
      forever
         #10 dsp_clk = ~dsp_clk;   // 20 ns period
   end

   // Galois LFSR for x^32 + x^22 + x^2 + x + 1 stepped once per bit
   function automatic logic lfsr_bit();
      logic out_bit;
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit)
         lfsr_state = lfsr_state ^ 32'h80200003;
      return out_bit;
   endfunction

   function automatic lms_data_pkg::adc_word_t random_word();
      lms_data_pkg::adc_word_t w;
      for (int b = 0; b < lms_data_pkg::ADC_WIDTH; b++)
         w[b] = lfsr_bit();
      return w;
   endfunction

   // Complement on inverted channels and zero-extend
   function automatic lms_data_pkg::sample_t expected_sample(int ch, lms_data_pkg::adc_word_t w);
      lms_data_pkg::adc_word_t raw;
      lms_data_pkg::sample_t   s;
      raw = INVERT_MASK[ch] ? ~w : w;
      s   = '0;
      s[lms_data_pkg::ADC_WIDTH-1:0] = raw;
      return s;
   endfunction

   task automatic flag_mismatch(string test, string what, logic [31:0] exp, logic [31:0] act);
      error_count++;
      $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h", test, what, exp, act);
      $display(">>> FAIL");
      $fatal(1, "%s stopped on a wrong value", test);
   endtask

   task automatic abort_on_timeout(string test, string what);
      error_count++;
      $display("Timeout in %s: %s", test, what);
      $display(">>> FAIL");
      $fatal(1, "%s stopped on a timeout", test);
   endtask

   task automatic expect_eq(string test, string what, logic [31:0] exp, logic [31:0] act);
      assert (act == exp)
      else
         flag_mismatch(test, what, exp, act);
   endtask

   // Returns at the falling edge of a run cycle in the wanted slot
   task automatic align_to_slot(string test, logic slot);
      int waited;
      waited = 0;
      @(negedge dsp_clk);
      while (!(frontend_run && (rx_iq_sel[0] == slot)))
      begin
         @(negedge dsp_clk);
         waited++;
         if (waited > WAIT_LIMIT)
            abort_on_timeout(test, "no run cycle in the wanted IQ slot");
      end
   endtask

   // ADC model and pair check with one queued word per run cycle from an I slot on
   task automatic stream_pairs(string test, int n_pairs);
      int p;
      align_to_slot(test, 1'b1);
      for (int cyc = 0; cyc <= 2 * n_pairs; cyc++)
      begin
         @(posedge dsp_clk);
         if (cyc < 2 * n_pairs)
            for (int ch = 0; ch < N_CH; ch++)
               adc[ch] <= stim_word[ch][cyc];
         @(negedge dsp_clk);
         expect_eq(test, "frontend_run_o", 1, frontend_run);
         for (int ch = 0; ch < N_CH; ch++)
         begin
            expect_eq(test, $sformatf("ch%0d rx_iq_sel_o", ch), cyc % 2, rx_iq_sel[ch]);
            if (cyc >= 1)
               expect_eq(test, $sformatf("ch%0d rx_valid_o", ch),
                         (cyc >= 2) && (cyc % 2 == 0), rx_valid[ch]);
            if ((cyc >= 2) && (cyc % 2 == 0))
            begin
               p = cyc / 2 - 1;   // Pair closed on the previous cycle
               expect_eq(test, $sformatf("ch%0d pair %0d rx_sample_i_o", ch, p),
                         expected_sample(ch, stim_word[ch][2 * p]), rx_sample_i[ch]);
               expect_eq(test, $sformatf("ch%0d pair %0d rx_sample_q_o", ch, p),
                         expected_sample(ch, stim_word[ch][2 * p + 1]), rx_sample_q[ch]);
            end
         end
      end
   endtask

   task automatic startup_test();
      string name;
      int    edges;
      name = "startup";
      @(negedge dsp_clk);
      expect_eq(name, "pll_reset_o after reset", 0, pll_reset);
      expect_eq(name, "frontend_run_o after reset", 0, frontend_run);
      expect_eq(name, "rx_valid_o after reset", 0, rx_valid);
      expect_eq(name, "rx_iq_sel_o after reset", 0, rx_iq_sel);
      expect_eq(name, "tx_iq_sel_o after reset", 0, tx_iq_sel);
      expect_eq(name, "dac_o after reset", 0, dac);
      @(posedge dsp_clk);
      clock_ready <= 1'b1;
      edges = 0;
      while (!frontend_run)
      begin
         @(posedge dsp_clk);
         @(negedge dsp_clk);
         edges++;
         if (edges > WAIT_LIMIT)
            abort_on_timeout(name, "frontend_run_o never rose");
         if (!frontend_run)
            expect_eq(name, "pll_reset_o while settling", 1, pll_reset);
      end
      // Edge k plus five more
      expect_eq(name, "edges from first high sample to run", lms_ctrl_pkg::READY_HISTORY, edges);
      expect_eq(name, "pll_reset_o while running", 0, pll_reset);
   endtask

   task automatic rx_pair_test();
      stim_word[0][0] = 12'h123;
      stim_word[0][1] = 12'hABC;
      stim_word[0][2] = 12'h000;
      stim_word[0][3] = 12'hFFF;
      stim_word[1][0] = 12'h5A5;
      stim_word[1][1] = 12'h0F0;
      stim_word[1][2] = 12'h800;
      stim_word[1][3] = 12'h7FF;
      stream_pairs("rx_pairs", 2);
   endtask

   task automatic tx_interleave_test();
      string name;
      name = "tx_interleave";
      @(posedge dsp_clk);
      dac_i <= TX_I_WORD;
      dac_q <= TX_Q_WORD;
      align_to_slot(name, 1'b0);   // Next cycle shows the I word
      for (int cyc = 0; cyc < 8; cyc++)
      begin
         @(posedge dsp_clk);
         @(negedge dsp_clk);
         if (cyc % 2 == 0)
         begin
            expect_eq(name, "dac_o on I", TX_I_LOW, dac);
            expect_eq(name, "tx_iq_sel_o on I", 0, tx_iq_sel);
         end
         else
         begin
            expect_eq(name, "dac_o on Q", TX_Q_LOW, dac);
            expect_eq(name, "tx_iq_sel_o on Q", 1, tx_iq_sel);
         end
      end
   endtask

   task automatic lock_loss_test();
      string                   name;
      int                      low_cycles;
      lms_data_pkg::adc_word_t word_i;
      lms_data_pkg::adc_word_t word_q;
      name   = "lock_loss";
      word_i = 12'h3C5;
      word_q = 12'hC3A;
      align_to_slot(name, 1'b0);
      @(posedge dsp_clk);
      clock_ready <= 1'b0;
      for (int ch = 0; ch < N_CH; ch++)
         adc[ch] <= word_i;   // Held for the first slot after restart
      @(posedge dsp_clk);
      clock_ready <= 1'b1;   // Low sample taken at this edge
      @(negedge dsp_clk);
      expect_eq(name, "frontend_run_o after low sample", 0, frontend_run);
      expect_eq(name, "pll_reset_o after low sample", 1, pll_reset);
      low_cycles = 1;
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      expect_eq(name, "dac_o while stopped", 0, dac);
      expect_eq(name, "tx_iq_sel_o while stopped", 0, tx_iq_sel);
      expect_eq(name, "rx_valid_o while stopped", 0, rx_valid);
      while (!frontend_run)
      begin
         expect_eq(name, "pll_reset_o while stopped", 1, pll_reset);
         low_cycles++;
         if (low_cycles > WAIT_LIMIT)
            abort_on_timeout(name, "frontend_run_o did not resume");
         @(posedge dsp_clk);
         @(negedge dsp_clk);
      end
      expect_eq(name, "cycles with run low", lms_ctrl_pkg::READY_HISTORY, low_cycles);
      expect_eq(name, "rx_iq_sel_o on first run cycle", 0, rx_iq_sel);
      expect_eq(name, "rx_valid_o on first run cycle", 0, rx_valid);
      @(posedge dsp_clk);
      for (int ch = 0; ch < N_CH; ch++)
         adc[ch] <= word_q;
      @(negedge dsp_clk);
      expect_eq(name, "rx_iq_sel_o on second run cycle", {N_CH{1'b1}}, rx_iq_sel);
      expect_eq(name, "first dac_o after restart", TX_I_LOW, dac);
      expect_eq(name, "first tx_iq_sel_o after restart", 0, tx_iq_sel);
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      expect_eq(name, "rx_valid_o for first pair", {N_CH{1'b1}}, rx_valid);
      for (int ch = 0; ch < N_CH; ch++)
      begin
         expect_eq(name, $sformatf("ch%0d first rx_sample_i_o", ch),
                   expected_sample(ch, word_i), rx_sample_i[ch]);
         expect_eq(name, $sformatf("ch%0d first rx_sample_q_o", ch),
                   expected_sample(ch, word_q), rx_sample_q[ch]);
      end
   endtask

   task automatic random_stream_test();
      for (int w = 0; w < MAX_WORDS; w++)
         for (int ch = 0; ch < N_CH; ch++)
            stim_word[ch][w] = random_word();
      stream_pairs("random_stream", MAX_WORDS / 2);
   endtask

   initial
   begin
      error_count = 0;
      lfsr_state  = 32'h62e36207;
      reset_i     = 1'b1;
      clock_ready = 1'b0;
      adc         = '0;
      dac_i       = '0;
      dac_q       = '0;
      repeat (3)
         @(posedge dsp_clk);
      reset_i <= 1'b0;
      startup_test();
      rx_pair_test();
      tx_interleave_test();
      lock_loss_test();
      random_stream_test();
      if (error_count == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== dv/lms_frontend_checker.sv ====
// Bound to lms_frontend_top; the receive checks run per channel and all checks pause during reset_i
`timescale 1ns/10ps

module lms_frontend_checker
   #(
   parameter int N_RX_CH = 2
   )
   (
   input  logic                    dsp_clk,
   input  logic                    reset_i,
   input  logic                    run_i,
   input  logic                    pll_reset_i,
   input  logic [N_RX_CH-1:0]      rx_iq_sel_i,
   input  logic [N_RX_CH-1:0]      rx_valid_i,
   input  logic                    tx_iq_sel_i,
   input  lms_data_pkg::dac_word_t tx_dac_i
   );

   // PLL reset and run are exclusive sequencer states
   assert property (@(posedge dsp_clk) disable iff (reset_i)
                    !(pll_reset_i && run_i))
      else $error("pll_reset_o and frontend_run_o high together");

   // Run only follows a settle phase covering the rest of the history
   assert property (@(posedge dsp_clk) disable iff (reset_i)
                    $rose(run_i) |-> $past(pll_reset_i, lms_ctrl_pkg::READY_HISTORY - 1))
      else $error("frontend_run_o rose without a full settle phase");

   for (genvar g = 0; g < N_RX_CH; g++)
   begin : gen_ch
      assert property (@(posedge dsp_clk) disable iff (reset_i)
                       rx_valid_i[g] |-> $past(rx_iq_sel_i[g] && run_i))
         else $error("rx_valid_o[%0d] without a Q slot in run on the cycle before", g);

      assert property (@(posedge dsp_clk) disable iff (reset_i)
                       (run_i && $past(run_i)) |-> (rx_iq_sel_i[g] != $past(rx_iq_sel_i[g])))
         else $error("rx_iq_sel_o[%0d] did not toggle during run", g);
   end

   // DAC bus parks one cycle after run drops
   assert property (@(posedge dsp_clk) disable iff (reset_i)
                    !run_i |=> ((tx_iq_sel_i == 1'b0) && (tx_dac_i == '0)))
      else $error("DAC outputs not idle after run went low");

endmodule

bind lms_frontend_top lms_frontend_checker
   #(
   .N_RX_CH (N_RX_CH)
   )
u_checker
   (
   .dsp_clk     (dsp_clk),
   .reset_i     (reset_i),
   .run_i       (frontend_run_o),
   .pll_reset_i (pll_reset_o),
   .rx_iq_sel_i (rx_iq_sel_o),
   .rx_valid_i  (rx_valid_o),
   .tx_iq_sel_i (tx_iq_sel_o),
   .tx_dac_i    (dac_o)
   );

// ==== hdl/lms_frontend_top.sv ====
// All converter pins are synchronous to dsp_clk; samples are offered once with no back-pressure
`timescale 1ns/10ps

module lms_frontend_top
   #(
   parameter int                 N_RX_CH        = 2,      // Receive channels on the board
   parameter logic [N_RX_CH-1:0] RX_INVERT_MASK = 2'b01   // One bit per channel
   )
   (
   input  logic                                   dsp_clk,
   input  logic                                   reset_i,
   input  logic                                   clock_ready_i,

   // Receive converters
   input  lms_data_pkg::adc_word_t [N_RX_CH-1:0]  adc_i,
   output logic                    [N_RX_CH-1:0]  rx_iq_sel_o,
   output lms_data_pkg::sample_t   [N_RX_CH-1:0]  rx_sample_i_o,
   output lms_data_pkg::sample_t   [N_RX_CH-1:0]  rx_sample_q_o,
   output logic                    [N_RX_CH-1:0]  rx_valid_o,

   // Transmit converter
   input  lms_data_pkg::dac_in_t                  dac_i_i,
   input  lms_data_pkg::dac_in_t                  dac_q_i,
   output lms_data_pkg::dac_word_t                dac_o,
   output logic                                   tx_iq_sel_o,

   // Clocking status
   output logic                                   pll_reset_o,
   output logic                                   frontend_run_o
   );

   logic                    run;
   lms_data_pkg::iq_phase_e phase;
   logic                    pair_end;

   converter_sequencer u_sequencer
      (
      .dsp_clk       (dsp_clk),
      .reset_i       (reset_i),
      .clock_ready_i (clock_ready_i),
      .pll_reset_o   (pll_reset_o),
      .run_o         (run),
      .phase_o       (phase),
      .pair_end_o    (pair_end)
      );

   assign frontend_run_o = run;

   // One deinterleaver per ADC, all on the shared phase
   for (genvar g = 0; g < N_RX_CH; g++)
   begin : gen_rx_ch
      rx_iq_deinterleave
         #(
         .INVERT (RX_INVERT_MASK[g])
         )
      u_rx
         (
         .dsp_clk    (dsp_clk),
         .reset_i    (reset_i),
         .run_i      (run),
         .phase_i    (phase),
         .pair_end_i (pair_end),
         .adc_i      (adc_i[g]),
         .iq_sel_o   (rx_iq_sel_o[g]),
         .sample_i_o (rx_sample_i_o[g]),
         .sample_q_o (rx_sample_q_o[g]),
         .valid_o    (rx_valid_o[g])
         );
   end

   tx_iq_interleave u_tx
      (
      .dsp_clk     (dsp_clk),
      .reset_i     (reset_i),
      .run_i       (run),
      .phase_i     (phase),
      .dac_i_i     (dac_i_i),
      .dac_q_i     (dac_q_i),
      .dac_o       (dac_o),
      .tx_iq_sel_o (tx_iq_sel_o)
      );

endmodule

// ==== hdl/tx_iq_interleave.sv ====
// Upper DAC input bits beyond the converter width are dropped, not saturated; outputs are idle when run is low
`timescale 1ns/10ps

module tx_iq_interleave
   (
   input  logic                    dsp_clk,
   input  logic                    reset_i,
   input  logic                    run_i,
   input  lms_data_pkg::iq_phase_e phase_i,
   input  lms_data_pkg::dac_in_t   dac_i_i,       // In-phase word from the DSP side
   input  lms_data_pkg::dac_in_t   dac_q_i,       // Quadrature word from the DSP side
   output lms_data_pkg::dac_word_t dac_o,
   output logic                    tx_iq_sel_o    // Low marks I on the DAC bus
   );

   lms_data_pkg::dac_word_t dac_i_trunc;
   lms_data_pkg::dac_word_t dac_q_trunc;

   // Converter takes only the low bits
   assign dac_i_trunc = dac_i_i[lms_data_pkg::DAC_WIDTH-1:0];
   assign dac_q_trunc = dac_q_i[lms_data_pkg::DAC_WIDTH-1:0];

   always_ff @(posedge dsp_clk)
   begin
      if (reset_i || !run_i)
      begin
         dac_o       <= '0;
         tx_iq_sel_o <= 1'b0;
      end
      else if (phase_i == lms_data_pkg::IQ_I)
      begin
         dac_o       <= dac_i_trunc;
         tx_iq_sel_o <= 1'b0;
      end
      else
      begin
         dac_o       <= dac_q_trunc;
         tx_iq_sel_o <= 1'b1;
      end
   end

endmodule

// ==== hdl/rx_iq_deinterleave.sv ====
// One ADC channel; the converter must put the word for the selected slot on adc_i in the same cycle
`timescale 1ns/10ps

module rx_iq_deinterleave
   #(
   parameter bit INVERT = 1'b0                 // Complement the raw word, undoes a board swap
   )
   (
   input  logic                    dsp_clk,
   input  logic                    reset_i,
   input  logic                    run_i,
   input  lms_data_pkg::iq_phase_e phase_i,
   input  logic                    pair_end_i,
   input  lms_data_pkg::adc_word_t adc_i,
   output logic                    iq_sel_o,   // Low asks for I, high for Q
   output lms_data_pkg::sample_t   sample_i_o,
   output lms_data_pkg::sample_t   sample_q_o,
   output logic                    valid_o
   );

   localparam int PAD = lms_data_pkg::SAMPLE_WIDTH - lms_data_pkg::ADC_WIDTH;

   lms_data_pkg::adc_word_t adc_word;
   lms_data_pkg::adc_word_t i_hold;

   assign adc_word = INVERT ? ~adc_i : adc_i;

   // Select follows the shared phase directly
   assign iq_sel_o = (phase_i == lms_data_pkg::IQ_Q);

   // I word waits here for its Q partner
   always_ff @(posedge dsp_clk)
   begin
      if (run_i && (phase_i == lms_data_pkg::IQ_I))
         i_hold <= adc_word;
   end

   // Pair register, refilled every second run cycle
   always_ff @(posedge dsp_clk)
   begin
      if (pair_end_i)
      begin
         sample_i_o <= {{PAD{1'b0}}, i_hold};
         sample_q_o <= {{PAD{1'b0}}, adc_word};   // Current word is the Q slot
      end
   end

   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
         valid_o <= 1'b0;
      else
         valid_o <= pair_end_i;   // One cycle per pair
   end

endmodule

// ==== hdl/converter_sequencer.sv ====
// Expects clock_ready_i synchronous to dsp_clk; a single low sample drops run for the whole history
`timescale 1ns/10ps

module converter_sequencer
   (
   input  logic                    dsp_clk,
   input  logic                    reset_i,
   input  logic                    clock_ready_i,   // Lock level from the clock chip
   output logic                    pll_reset_o,
   output logic                    run_o,
   output lms_data_pkg::iq_phase_e phase_o,
   output logic                    pair_end_o       // Last slot of an I/Q pair
   );

   logic [lms_ctrl_pkg::READY_HISTORY-1:0] ready_hist;
   logic [lms_ctrl_pkg::READY_HISTORY-1:0] ready_hist_next;
   lms_ctrl_pkg::seq_state_e               state;
   lms_ctrl_pkg::seq_state_e               state_next;
   lms_data_pkg::iq_phase_e                phase;
   logic                                   stay_run;

   // Newest lock sample enters at bit 0
   assign ready_hist_next = {ready_hist[lms_ctrl_pkg::READY_HISTORY-2:0], clock_ready_i};

   always_comb
   begin
      if (ready_hist_next == '0)
         state_next = lms_ctrl_pkg::SEQ_IDLE;
      else if (&ready_hist_next)
         state_next = lms_ctrl_pkg::SEQ_RUN;
      else
         state_next = lms_ctrl_pkg::SEQ_SETTLE;
   end

   // Phase only advances between two run cycles
   assign stay_run = (state == lms_ctrl_pkg::SEQ_RUN) &&
                     (state_next == lms_ctrl_pkg::SEQ_RUN);

   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         ready_hist <= '0;
         state      <= lms_ctrl_pkg::SEQ_IDLE;
      end
      else
      begin
         ready_hist <= ready_hist_next;
         state      <= state_next;
      end
   end

   // First run cycle always lands on the I slot
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
         phase <= lms_data_pkg::IQ_I;
      else if (stay_run)
      begin
         if (phase == lms_data_pkg::IQ_I)
            phase <= lms_data_pkg::IQ_Q;
         else
            phase <= lms_data_pkg::IQ_I;
      end
      else
         phase <= lms_data_pkg::IQ_I;   // Parked while stopped
   end

   assign pll_reset_o = (state == lms_ctrl_pkg::SEQ_SETTLE);   // Partial history only
   assign run_o       = (state == lms_ctrl_pkg::SEQ_RUN);
   assign phase_o     = phase;

   // Shared strobe so every channel closes its pair on the same cycle
   assign pair_end_o  = run_o && (phase == lms_data_pkg::IQ_Q);

endmodule

// ==== hdl/lms_ctrl_pkg.sv ====
// Ready history length assumes the lock level is already synchronous to dsp_clk
package lms_ctrl_pkg;

   // Consecutive high lock samples before the converters are enabled
   parameter int READY_HISTORY = 6;

   // Sequencer state, derived from the lock history
   typedef enum logic [1:0]
   {
      SEQ_IDLE   = 2'b00,                  // History empty, no lock seen
      SEQ_SETTLE = 2'b01,                  // History partly filled, PLL held in reset
      SEQ_RUN    = 2'b10                   // History full, converters running
   } seq_state_e;

endpackage

// ==== hdl/lms_data_pkg.sv ====
// Widths are fixed for the interleaved-IQ converter: 12-bit ADC/DAC words, 14-bit samples, 16-bit DSP-side DAC words
package lms_data_pkg;

   // Converter side
   parameter int ADC_WIDTH = 12;          // Raw ADC word from the converter
   parameter int DAC_WIDTH = 12;          // DAC word taken by the converter

   // DSP side
   parameter int SAMPLE_WIDTH = 14;       // Zero-extended receive sample
   parameter int DAC_IN_WIDTH = 16;       // Transmit word before truncation

   // Raw ADC word as it appears on the converter bus
   typedef logic [ADC_WIDTH-1:0] adc_word_t;

   // Receive sample presented to the DSP chain
   typedef logic [SAMPLE_WIDTH-1:0] sample_t;

   // Transmit word from the DSP chain, only the low bits reach the DAC
   typedef logic [DAC_IN_WIDTH-1:0] dac_in_t;

   // Word driven onto the converter DAC bus
   typedef logic [DAC_WIDTH-1:0] dac_word_t;

   // Slot of the shared IQ bus
   // IQ_I maps to a low select line, IQ_Q to a high one
   typedef enum logic
   {
      IQ_I = 1'b0,                         // In-phase slot
      IQ_Q = 1'b1                          // Quadrature slot
   } iq_phase_e;

endpackage
